// File: hw/sram_test_pkg.sv
// SRAM tester shared types

package sram_test_pkg;

  // data backgrounds, listed in run order
  typedef enum logic [1:0] {
    pat_zeros       = 2'd0,
    pat_ones        = 2'd1,
    pat_checker     = 2'd2, // alternating, lsb set
    pat_inv_checker = 2'd3  // alternating, lsb clear
  } pattern_kind_e;

  // access direction on the sram bus
  typedef enum logic {
    op_write = 1'b0,
    op_read  = 1'b1
  } mem_op_e;

  // miscompare counter width, saturates at all ones
  localparam int ERR_COUNT_BITS = 8;

endpackage

// File: hw/address_generator.sv
// SRAM address sweep counter

`timescale 1ns/1ps

module address_generator #(
  parameter int ADDR_BITS = 20
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 restart_i,
  input  logic                 dir_i,
  input  logic                 step_i,
  output logic [ADDR_BITS-1:0] addr_o,
  output logic                 last_o
);

  localparam logic [ADDR_BITS-1:0] ADDR_MAX = {ADDR_BITS{1'b1}};

  logic [ADDR_BITS-1:0] addr_q;
  logic                 down_q;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      addr_q <= '0;
      down_q <= 1'b0;
    end else if (restart_i) begin
      // up sweeps start at zero, down sweeps at the top
      addr_q <= dir_i ? ADDR_MAX : '0;
      down_q <= dir_i;
    end else if (step_i) begin
      if (down_q) begin
        addr_q <= addr_q - 1'b1;
      end else begin
        addr_q <= addr_q + 1'b1;
      end
    end
  end

  assign addr_o = addr_q;
  assign last_o = down_q ? (addr_q == '0) : (addr_q == ADDR_MAX);

endmodule

// File: hw/pattern_generator.sv
// Background and expected word generator

`timescale 1ns/1ps

module pattern_generator import sram_test_pkg::*; #(
  parameter int ADDR_BITS = 20,
  parameter int DATA_BITS = 16
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 restart_i,
  input  logic                 step_i,
  input  logic [ADDR_BITS-1:0] addr_i,
  output pattern_kind_e        kind_o,
  output logic                 last_o,
  output logic [DATA_BITS-1:0] data_o
);

  pattern_kind_e                      kind_q;
  logic [DATA_BITS-1:0]               checker_bg;
  logic [DATA_BITS-1:0]               background;
  logic [ADDR_BITS+DATA_BITS-1:0]     addr_wide;
  logic [DATA_BITS-1:0]               seed;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      kind_q <= pat_zeros;
    end else if (restart_i) begin
      kind_q <= pat_zeros;
    end else if (step_i) begin
      kind_q <= pattern_kind_e'(kind_q + 2'd1);
    end
  end

  // alternating ones and zeros, bit 0 set
  for (genvar i = 0; i < DATA_BITS; i++) begin : g_checker
    assign checker_bg[i] = ((i % 2) == 0);
  end

  always_comb begin
    case (kind_q)
      pat_zeros:   background = '0;
      pat_ones:    background = '1;
      pat_checker: background = checker_bg;
      default:     background = ~checker_bg;
    endcase
  end

  // address zero-extended when narrower than the data word
  assign addr_wide = {{DATA_BITS{1'b0}}, addr_i};
  assign seed      = addr_wide[DATA_BITS-1:0];

  assign data_o = background ^ seed;
  assign kind_o = kind_q;
  assign last_o = (kind_q == pat_inv_checker);

endmodule

// File: hw/sram_controller.sv
// Asynchronous SRAM bus controller

`timescale 1ns/1ps

module sram_controller import sram_test_pkg::*; #(
  parameter int ADDR_BITS = 20,
  parameter int DATA_BITS = 16
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 req_i,
  input  mem_op_e              op_i,
  input  logic [ADDR_BITS-1:0] addr_i,
  input  logic [DATA_BITS-1:0] wdata_i,
  output logic                 done_o,
  output logic [DATA_BITS-1:0] rdata_o,
  output logic [ADDR_BITS-1:0] sram_addr_o,
  inout  wire  [DATA_BITS-1:0] sram_data_io,
  output logic                 ce_n_o,
  output logic                 oe_n_o,
  output logic                 we_n_o
);

  typedef enum logic [1:0] {
    st_idle,
    st_access,
    st_finish
  } ctrl_state_e;

  ctrl_state_e          state_q;
  logic                 ce_n_q;
  logic                 oe_n_q;
  logic                 we_n_q;
  logic                 data_oe;
  logic [ADDR_BITS-1:0] addr_q;
  logic [DATA_BITS-1:0] wdata_q;
  logic [DATA_BITS-1:0] rdata_q;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state_q <= st_idle;
      ce_n_q  <= 1'b1;
      oe_n_q  <= 1'b1;
      we_n_q  <= 1'b1;
    end else begin
      case (state_q)
        st_idle: begin
          if (req_i) begin
            state_q <= st_access;
            ce_n_q  <= 1'b0;
            oe_n_q  <= (op_i != op_read);
            we_n_q  <= (op_i != op_write);
          end
        end
        st_access: begin
          // end of the strobe cycle, everything released together
          state_q <= st_finish;
          ce_n_q  <= 1'b1;
          oe_n_q  <= 1'b1;
          we_n_q  <= 1'b1;
        end
        default: state_q <= st_idle;
      endcase
    end
  end

  // address, write data and read data
  always_ff @(posedge clk) begin
    if (state_q == st_idle && req_i) begin
      addr_q  <= addr_i;
      wdata_q <= wdata_i;
    end
    if (state_q == st_access && !oe_n_q) begin
      rdata_q <= sram_data_io;
    end
  end

  // bus is only driven during the write strobe
  assign data_oe      = ~we_n_q;
  assign sram_data_io = data_oe ? wdata_q : {DATA_BITS{1'bz}};

  assign done_o      = (state_q == st_finish);
  assign rdata_o     = rdata_q;
  assign sram_addr_o = addr_q;
  assign ce_n_o      = ce_n_q;
  assign oe_n_o      = oe_n_q;
  assign we_n_o      = we_n_q;

endmodule

// File: hw/test_sequencer.sv
// SRAM test run sequencer

`timescale 1ns/1ps

module test_sequencer import sram_test_pkg::*; (
  input  logic    clk,
  input  logic    reset,
  input  logic    start_req_i,
  output logic    start_ack_o,
  input  logic    addr_last_i,
  input  logic    pat_last_i,
  input  logic    mem_done_i,
  output logic    addr_restart_o,
  output logic    addr_dir_o,
  output logic    addr_step_o,
  output logic    pat_restart_o,
  output logic    pat_step_o,
  output logic    mem_req_o,
  output mem_op_e mem_op_o,
  output logic    check_en_o,
  output logic    clear_o
);

  typedef enum logic [2:0] {
    seq_idle,
    seq_clear,
    seq_issue,
    seq_wait,
    seq_ack
  } seq_state_e;

  seq_state_e state_q;
  seq_state_e state_d;
  mem_op_e    op_q;
  mem_op_e    op_d;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state_q <= seq_idle;
      op_q    <= op_write;
    end else begin
      state_q <= state_d;
      op_q    <= op_d;
    end
  end

  always_comb begin
    state_d        = state_q;
    op_d           = op_q;
    addr_restart_o = 1'b0;
    addr_dir_o     = 1'b0;
    addr_step_o    = 1'b0;
    pat_restart_o  = 1'b0;
    pat_step_o     = 1'b0;
    mem_req_o      = 1'b0;
    check_en_o     = 1'b0;
    clear_o        = 1'b0;
    case (state_q)
      seq_idle: begin
        // req only stays high here once ack has dropped
        if (start_req_i) begin
          state_d = seq_clear;
        end
      end
      seq_clear: begin
        clear_o        = 1'b1;
        pat_restart_o  = 1'b1;
        addr_restart_o = 1'b1;
        op_d           = op_write;
        state_d        = seq_issue;
      end
      seq_issue: begin
        mem_req_o = 1'b1;
        state_d   = seq_wait;
      end
      seq_wait: begin
        if (mem_done_i) begin
          check_en_o = (op_q == op_read);
          state_d    = seq_issue;
          if (!addr_last_i) begin
            addr_step_o = 1'b1;
          end else if (op_q == op_write) begin
            // write sweep done, read back from the top
            addr_restart_o = 1'b1;
            addr_dir_o     = 1'b1;
            op_d           = op_read;
          end else if (!pat_last_i) begin
            pat_step_o     = 1'b1;
            addr_restart_o = 1'b1;
            op_d           = op_write;
          end else begin
            state_d = seq_ack;
          end
        end
      end
      seq_ack: begin
        if (!start_req_i) begin
          state_d = seq_idle;
        end
      end
      default: state_d = seq_idle;
    endcase
  end

  assign start_ack_o = (state_q == seq_ack);
  assign mem_op_o    = op_q;

endmodule

// File: hw/result_checker.sv
// Read data checker

`timescale 1ns/1ps

module result_checker import sram_test_pkg::*; #(
  parameter int ADDR_BITS = 20,
  parameter int DATA_BITS = 16
) (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      clear_i,
  input  logic                      check_en_i,
  input  logic [DATA_BITS-1:0]      rdata_i,
  input  logic [DATA_BITS-1:0]      expected_i,
  input  logic [ADDR_BITS-1:0]      addr_i,
  output logic                      pass_o,
  output logic [ERR_COUNT_BITS-1:0] err_count_o,
  output logic [ADDR_BITS-1:0]      fail_addr_o
);

  localparam logic [ERR_COUNT_BITS-1:0] COUNT_MAX = {ERR_COUNT_BITS{1'b1}};

  logic                      pass_q;
  logic [ERR_COUNT_BITS-1:0] count_q;
  logic [ADDR_BITS-1:0]      fail_addr_q;
  logic                      miscompare;

  assign miscompare = check_en_i && (rdata_i != expected_i);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      pass_q      <= 1'b0;
      count_q     <= '0;
      fail_addr_q <= '0;
    end else if (clear_i) begin
      pass_q      <= 1'b1;
      count_q     <= '0;
      fail_addr_q <= '0;
    end else if (miscompare) begin
      pass_q <= 1'b0;
      if (count_q != COUNT_MAX) begin
        count_q <= count_q + 1'b1;
      end
      // pass still set means no earlier error this run
      if (pass_q) begin
        fail_addr_q <= addr_i;
      end
    end
  end

  assign pass_o      = pass_q;
  assign err_count_o = count_q;
  assign fail_addr_o = fail_addr_q;

endmodule

// File: hw/sram_tester.sv
// SRAM built-in self-test top

`timescale 1ns/1ps

module sram_tester import sram_test_pkg::*; #(
  parameter int ADDR_BITS = 20,
  parameter int DATA_BITS = 16
) (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      start_req_i,
  output logic                      start_ack_o,
  output logic                      pass_o,
  output logic [ERR_COUNT_BITS-1:0] err_count_o,
  output logic [ADDR_BITS-1:0]      fail_addr_o,
  output logic [ADDR_BITS-1:0]      sram_addr_o,
  inout  wire  [DATA_BITS-1:0]      sram_data_io,
  output logic                      ce_n_o,
  output logic                      oe_n_o,
  output logic                      we_n_o
);

  logic                 addr_restart;
  logic                 addr_dir;
  logic                 addr_step;
  logic                 addr_last;
  logic [ADDR_BITS-1:0] addr;
  logic                 pat_restart;
  logic                 pat_step;
  logic                 pat_last;
  logic [DATA_BITS-1:0] pattern;
  logic                 mem_req;
  mem_op_e              mem_op;
  logic                 mem_done;
  logic [DATA_BITS-1:0] read_data;
  logic                 check_en;
  logic                 clear;

  address_generator #(
    .ADDR_BITS(ADDR_BITS)
  ) u_addr_gen (
    .clk      (clk),
    .reset    (reset),
    .restart_i(addr_restart),
    .dir_i    (addr_dir),
    .step_i   (addr_step),
    .addr_o   (addr),
    .last_o   (addr_last)
  );

  // same word is write data and expected read data
  pattern_generator #(
    .ADDR_BITS(ADDR_BITS),
    .DATA_BITS(DATA_BITS)
  ) u_pat_gen (
    .clk      (clk),
    .reset    (reset),
    .restart_i(pat_restart),
    .step_i   (pat_step),
    .addr_i   (addr),
    .kind_o   (),
    .last_o   (pat_last),
    .data_o   (pattern)
  );

  test_sequencer u_seq (
    .clk           (clk),
    .reset         (reset),
    .start_req_i   (start_req_i),
    .start_ack_o   (start_ack_o),
    .addr_last_i   (addr_last),
    .pat_last_i    (pat_last),
    .mem_done_i    (mem_done),
    .addr_restart_o(addr_restart),
    .addr_dir_o    (addr_dir),
    .addr_step_o   (addr_step),
    .pat_restart_o (pat_restart),
    .pat_step_o    (pat_step),
    .mem_req_o     (mem_req),
    .mem_op_o      (mem_op),
    .check_en_o    (check_en),
    .clear_o       (clear)
  );

  sram_controller #(
    .ADDR_BITS(ADDR_BITS),
    .DATA_BITS(DATA_BITS)
  ) u_ctrl (
    .clk         (clk),
    .reset       (reset),
    .req_i       (mem_req),
    .op_i        (mem_op),
    .addr_i      (addr),
    .wdata_i     (pattern),
    .done_o      (mem_done),
    .rdata_o     (read_data),
    .sram_addr_o (sram_addr_o),
    .sram_data_io(sram_data_io),
    .ce_n_o      (ce_n_o),
    .oe_n_o      (oe_n_o),
    .we_n_o      (we_n_o)
  );

  result_checker #(
    .ADDR_BITS(ADDR_BITS),
    .DATA_BITS(DATA_BITS)
  ) u_checker (
    .clk        (clk),
    .reset      (reset),
    .clear_i    (clear),
    .check_en_i (check_en),
    .rdata_i    (read_data),
    .expected_i (pattern),
    .addr_i     (addr),
    .pass_o     (pass_o),
    .err_count_o(err_count_o),
    .fail_addr_o(fail_addr_o)
  );

endmodule

// File: tb/sram_model.sv
// Behavioral asynchronous SRAM

`timescale 1ns/1ps

module sram_model #(
  parameter int ADDR_BITS = 6,
  parameter int DATA_BITS = 8
) (
  input  logic [ADDR_BITS-1:0]         addr_i,
  inout  wire  [DATA_BITS-1:0]         data_io,
  input  logic                         ce_n_i,
  input  logic                         oe_n_i,
  input  logic                         we_n_i,
  input  logic                         fault_en_i,
  input  logic [ADDR_BITS-1:0]         fault_addr_i,
  input  logic [$clog2(DATA_BITS)-1:0] fault_bit_i,
  input  logic                         fault_val_i
);

  localparam int WORDS       = 1 << ADDR_BITS;
  localparam int WRITE_SETUP = 2;

  logic [DATA_BITS-1:0] mem [0:WORDS-1];
  logic [DATA_BITS-1:0] write_word;

  // data taken a little after the write strobe falls
  always @(negedge we_n_i) begin
    #WRITE_SETUP;
    if (!ce_n_i && !we_n_i) begin
      write_word = data_io;
      // stuck cell keeps one bit at a fixed level
      if (fault_en_i && addr_i == fault_addr_i) begin
        write_word[fault_bit_i] = fault_val_i;
      end
      mem[addr_i] = write_word;
    end
  end

  // output drivers follow ce and oe
  assign data_io = (!ce_n_i && !oe_n_i) ? mem[addr_i] : {DATA_BITS{1'bz}};

endmodule

// File: tb/tb_sram_tester.sv
// SRAM tester testbench

`timescale 1ns/1ps

module tb_sram_tester import sram_test_pkg::*; #(
  parameter int ADDR_BITS = 6,
  parameter int DATA_BITS = 8
);

  localparam int WORDS       = 1 << ADDR_BITS;
  localparam int BIT_SEL     = $clog2(DATA_BITS);
  localparam int NUM_RUNS    = 5;
  localparam int MAX_DELAY   = 20;
  localparam int RUN_CYCLES  = 4 * 2 * WORDS * 3 + 8;
  localparam int CYCLE_LIMIT = 2 * (NUM_RUNS * RUN_CYCLES + NUM_RUNS * 2 * MAX_DELAY) + 10;

  logic                      clk;
  logic                      reset;
  logic                      start_req;
  logic                      start_ack;
  logic                      pass;
  logic [ERR_COUNT_BITS-1:0] err_count;
  logic [ADDR_BITS-1:0]      fail_addr;
  logic [ADDR_BITS-1:0]      sram_addr;
  wire  [DATA_BITS-1:0]      sram_data;
  logic                      ce_n;
  logic                      oe_n;
  logic                      we_n;
  logic                      fault_en;
  logic [ADDR_BITS-1:0]      fault_addr;
  logic [BIT_SEL-1:0]        fault_bit;
  logic                      fault_val;
  logic                      prev_req;
  logic                      prev_ack;
  integer                    seed;
  int                        errors;
  int                        test_errors;
  int                        tests_run;
  int                        tests_failed;
  int                        cycle_count;

  sram_tester #(
    .ADDR_BITS(ADDR_BITS),
    .DATA_BITS(DATA_BITS)
  ) DUT (
    .clk         (clk),
    .reset       (reset),
    .start_req_i (start_req),
    .start_ack_o (start_ack),
    .pass_o      (pass),
    .err_count_o (err_count),
    .fail_addr_o (fail_addr),
    .sram_addr_o (sram_addr),
    .sram_data_io(sram_data),
    .ce_n_o      (ce_n),
    .oe_n_o      (oe_n),
    .we_n_o      (we_n)
  );

  sram_model #(
    .ADDR_BITS(ADDR_BITS),
    .DATA_BITS(DATA_BITS)
  ) u_sram (
    .addr_i      (sram_addr),
    .data_io     (sram_data),
    .ce_n_i      (ce_n),
    .oe_n_i      (oe_n),
    .we_n_i      (we_n),
    .fault_en_i  (fault_en),
    .fault_addr_i(fault_addr),
    .fault_bit_i (fault_bit),
    .fault_val_i (fault_val)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // background XOR zero-extended address
  function automatic logic [DATA_BITS-1:0] expected_word(input pattern_kind_e kind,
                                                         input logic [ADDR_BITS-1:0] addr);
    logic [DATA_BITS-1:0] word;
    int i;
    for (i = 0; i < DATA_BITS; i++) begin
      case (kind)
        pat_zeros:   word[i] = 1'b0;
        pat_ones:    word[i] = 1'b1;
        pat_checker: word[i] = (i % 2 == 0);
        default:     word[i] = (i % 2 == 1);
      endcase
      if (i < ADDR_BITS) begin
        word[i] = word[i] ^ addr[i];
      end
    end
    return word;
  endfunction

  // one miscompare per background whose expected bit differs from the stuck level
  function automatic int expected_errors(input logic en, input logic [BIT_SEL-1:0] bit_sel,
                                         input logic val, input logic [ADDR_BITS-1:0] addr);
    logic [DATA_BITS-1:0] word;
    int k;
    int count;
    count = 0;
    for (k = 0; k < 4; k++) begin
      word = expected_word(pattern_kind_e'(k), addr);
      if (en && word[bit_sel] != val) begin
        count++;
      end
    end
    return count;
  endfunction

  task automatic report_mismatch(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
    $display("Fail at %0d ns: %s is %0d, expected %0d", $time, name, got, exp);
    errors++;
    test_errors++;
  endtask

  task automatic report_problem(input string msg);
    $display("Error at %0d ns: %s", $time, msg);
    errors++;
    test_errors++;
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (test_errors == 0) begin
      $display("test %0d %s: ok", tests_run, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: %0d errors", tests_run, name, test_errors);
    end
    test_errors = 0;
  endtask

  // one full handshake with results compared while ack is high
  task automatic run_once(input logic with_fault);
    int                   exp_count;
    logic [ADDR_BITS-1:0] exp_addr;
    fault_en   = with_fault;
    fault_addr = $random(seed);
    fault_bit  = $unsigned($random(seed)) % DATA_BITS;
    fault_val  = $random(seed);
    repeat ($unsigned($random(seed)) % (MAX_DELAY + 1)) @(negedge clk);
    if (start_ack !== 1'b0) begin
      report_problem("start_ack_o high before the request");
    end
    start_req = 1'b1;
    while (!start_ack) @(negedge clk);
    exp_count = expected_errors(with_fault, fault_bit, fault_val, fault_addr);
    exp_addr  = (exp_count != 0) ? fault_addr : '0;
    if (pass !== (exp_count == 0)) begin
      report_mismatch("pass_o", pass, exp_count == 0);
    end
    if (fail_addr !== exp_addr) begin
      report_mismatch("fail_addr_o", fail_addr, exp_addr);
    end
    repeat ($unsigned($random(seed)) % (MAX_DELAY + 1)) begin
      if (err_count !== exp_count) begin
        report_mismatch("err_count_o", err_count, exp_count);
      end
      @(negedge clk);
    end
    if (err_count !== exp_count) begin
      report_mismatch("err_count_o", err_count, exp_count);
    end
    start_req = 1'b0;
    while (start_ack) @(negedge clk);
  endtask

  task automatic check_memory;
    logic [DATA_BITS-1:0] exp;
    int a;
    for (a = 0; a < WORDS; a++) begin
      exp = expected_word(pat_inv_checker, a);
      if (u_sram.mem[a] !== exp) begin
        report_mismatch($sformatf("mem[%0d]", a), u_sram.mem[a], exp);
      end
    end
  endtask

  // bus and handshake monitor on values settled since the last edge
  always @(posedge clk) begin
    if (!reset) begin
      if (!we_n && !oe_n) begin
        report_problem("we_n_o and oe_n_o low together");
      end
      if (we_n && oe_n && sram_data !== {DATA_BITS{1'bz}}) begin
        report_problem("data bus driven while we_n_o is high");
      end
      if (!ce_n && !oe_n && (^sram_data) === 1'bx) begin
        report_problem("data bus contention during a read");
      end
      if (start_ack && !prev_ack && !prev_req) begin
        report_problem("start_ack_o rose without start_req_i");
      end
      if (!start_ack && prev_ack && prev_req) begin
        report_problem("start_ack_o fell while start_req_i was high");
      end
    end
    prev_ack <= start_ack;
    prev_req <= start_req;
  end

  initial begin
    cycle_count = 0;
    while (cycle_count < CYCLE_LIMIT) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Timeout: the run hung, no result after %0d cycles", cycle_count);
    $display("Done: errors found");
    $finish;
  end

  initial begin
    int i;
    seed         = 47597;
    errors       = 0;
    test_errors  = 0;
    tests_run    = 0;
    tests_failed = 0;
    reset        = 1'b1;
    start_req    = 1'b0;
    fault_en     = 1'b0;
    fault_addr   = '0;
    fault_bit    = '0;
    fault_val    = 1'b0;
    repeat (5) @(negedge clk);
    reset = 1'b0;
    @(negedge clk);

    if (start_ack !== 1'b0) begin
      report_mismatch("start_ack_o", start_ack, 0);
    end
    if (pass !== 1'b0) begin
      report_mismatch("pass_o", pass, 0);
    end
    if (err_count !== 0) begin
      report_mismatch("err_count_o", err_count, 0);
    end
    if (fail_addr !== 0) begin
      report_mismatch("fail_addr_o", fail_addr, 0);
    end
    if (ce_n !== 1'b1) begin
      report_mismatch("ce_n_o", ce_n, 1);
    end
    if (oe_n !== 1'b1) begin
      report_mismatch("oe_n_o", oe_n, 1);
    end
    if (we_n !== 1'b1) begin
      report_mismatch("we_n_o", we_n, 1);
    end
    if (sram_data !== {DATA_BITS{1'bz}}) begin
      report_problem("data bus not released after reset");
    end
    finish_test("reset values");

    run_once(1'b0);
    finish_test("fault-free run");
    check_memory();
    finish_test("memory contents");
    run_once(1'b1);
    finish_test("stuck-at fault");

    // each run has to clear what the fault run left behind
    for (i = 0; i < 3; i++) begin
      run_once(i % 2 == 1);
    end
    finish_test("back-to-back runs");

    @(negedge clk);
    $display("tests: %0d run, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// File: filelist.f
hw/sram_test_pkg.sv
hw/address_generator.sv
hw/pattern_generator.sv
hw/sram_controller.sv
hw/test_sequencer.sv
hw/result_checker.sv
hw/sram_tester.sv
tb/sram_model.sv
tb/tb_sram_tester.sv
